// File: Bender.yml
package:
  name: filter_bank

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/filter_bank_pkg.sv
      - filter_lane/pair_distance.sv
      - filter_lane/pair_buffer.sv
      - hw/pair_arbiter.sv
      - hw/pair_selector.sv
      - hw/filter_bank.sv

  - target: test
    include_dirs:
      - common
    files:
      - verification/filter_bank_tb.sv

// File: common/filter_bank_defs.svh
////////////////////
// Coordinates are Q7.8 signed fixed point, so the squared cutoff carries 16 fraction bits
// Buffer depth must be a power of two and match the address width
////////////////////
`ifndef FILTER_BANK_DEFS_SVH
`define FILTER_BANK_DEFS_SVH

// Number of parallel filter lanes
`define FB_NUM_LANES 4

// Signed coordinate width
`define FB_COORD_W 16

// Particle id width
`define FB_ID_W 12

// Per-lane buffer sizing
`define FB_BUF_DEPTH 16
`define FB_BUF_AW    4

// Free entries below which back-pressure rises
// Covers 2 distance stages plus the strobe already on the wires
`define FB_BP_SLACK 4

// 12.0 squared in Q7.8, i.e. 144 << 16
`define FB_CUTOFF_2 34'd9437184

`endif

// File: common/filter_bank_pkg.sv
////////////////////
// Datapath types for the filter bank, sized from the defs header
////////////////////
`include "filter_bank_defs.svh"

package filter_bank_pkg;

	// Particle position on one axis
	typedef logic signed [`FB_COORD_W-1:0] coord_t;

	// Particle id
	typedef logic [`FB_ID_W-1:0] pid_t;

	// One extra bit so ref minus neighbor never overflows
	typedef logic signed [`FB_COORD_W:0] delta_t;

	// Sum of three squared deltas
	// Each square is at most 2^32, three of them fit in 34 bits
	typedef logic [2*`FB_COORD_W+1:0] dist2_t;

	// One bit per lane
	typedef logic [`FB_NUM_LANES-1:0] lane_mask_t;

endpackage

// File: filter_lane/pair_buffer.sv
////////////////////
// Writes arriving while full are dropped, so the source must honor back_pressure
// Read data changes only on a pop and holds otherwise
////////////////////
`timescale 1ns/1ps
`include "filter_bank_defs.svh"

module pair_buffer
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    wr_valid,
	input  filter_bank_pkg::pid_t   wr_ref_id,
	input  filter_bank_pkg::pid_t   wr_nbr_id,
	input  filter_bank_pkg::delta_t wr_dx,
	input  filter_bank_pkg::delta_t wr_dy,
	input  filter_bank_pkg::delta_t wr_dz,
	input  filter_bank_pkg::dist2_t wr_r2,
	input  logic                    pop,
	output logic                    available,
	output logic                    back_pressure,
	output filter_bank_pkg::pid_t   rd_ref_id,
	output filter_bank_pkg::pid_t   rd_nbr_id,
	output filter_bank_pkg::delta_t rd_dx,
	output filter_bank_pkg::delta_t rd_dy,
	output filter_bank_pkg::delta_t rd_dz,
	output filter_bank_pkg::dist2_t rd_r2
);
	import filter_bank_pkg::*;

	// Storage, one array per field
	pid_t   mem_ref_id [`FB_BUF_DEPTH];
	pid_t   mem_nbr_id [`FB_BUF_DEPTH];
	delta_t mem_dx     [`FB_BUF_DEPTH];
	delta_t mem_dy     [`FB_BUF_DEPTH];
	delta_t mem_dz     [`FB_BUF_DEPTH];
	dist2_t mem_r2     [`FB_BUF_DEPTH];

	logic [`FB_BUF_AW-1:0] wr_ptr;
	logic [`FB_BUF_AW-1:0] rd_ptr;
	logic [`FB_BUF_AW:0]   count;   // One extra bit to hold the full value
	logic                  full;
	logic                  do_wr;
	logic                  do_rd;

	assign full          = (count == `FB_BUF_DEPTH);
	assign available     = (count != '0);
	assign do_wr         = wr_valid && !full;
	assign do_rd         = pop && available;
	assign back_pressure = (count > (`FB_BUF_DEPTH - `FB_BP_SLACK)); // Free below slack

	////////////////////
	// Pointers and count
	////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at the power-of-two depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	// Storage write and registered read
	always_ff @(posedge clk)
	begin
		if (do_wr)
		begin
			mem_ref_id[wr_ptr] <= wr_ref_id;
			mem_nbr_id[wr_ptr] <= wr_nbr_id;
			mem_dx[wr_ptr]     <= wr_dx;
			mem_dy[wr_ptr]     <= wr_dy;
			mem_dz[wr_ptr]     <= wr_dz;
			mem_r2[wr_ptr]     <= wr_r2;
		end
		if (do_rd)
		begin
			rd_ref_id <= mem_ref_id[rd_ptr];
			rd_nbr_id <= mem_nbr_id[rd_ptr];
			rd_dx     <= mem_dx[rd_ptr];
			rd_dy     <= mem_dy[rd_ptr];
			rd_dz     <= mem_dz[rd_ptr];
			rd_r2     <= mem_r2[rd_ptr];
		end
	end

endmodule

// File: filter_lane/pair_distance.sv
////////////////////
// Fixed 2 cycle latency, a new pair may enter every cycle
// Pairs at or beyond the cutoff never raise acc_valid
////////////////////
`timescale 1ns/1ps
`include "filter_bank_defs.svh"

module pair_distance
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    in_valid,
	input  filter_bank_pkg::pid_t   ref_id,
	input  filter_bank_pkg::pid_t   nbr_id,
	input  filter_bank_pkg::coord_t ref_x,
	input  filter_bank_pkg::coord_t ref_y,
	input  filter_bank_pkg::coord_t ref_z,
	input  filter_bank_pkg::coord_t nbr_x,
	input  filter_bank_pkg::coord_t nbr_y,
	input  filter_bank_pkg::coord_t nbr_z,
	output logic                    acc_valid,
	output filter_bank_pkg::pid_t   acc_ref_id,
	output filter_bank_pkg::pid_t   acc_nbr_id,
	output filter_bank_pkg::delta_t acc_dx,
	output filter_bank_pkg::delta_t acc_dy,
	output filter_bank_pkg::delta_t acc_dz,
	output filter_bank_pkg::dist2_t acc_r2
);
	import filter_bank_pkg::*;

	// Stage one
	logic   s1_valid;
	pid_t   s1_ref_id;
	pid_t   s1_nbr_id;
	delta_t s1_dx;
	delta_t s1_dy;
	delta_t s1_dz;

	// Stage two arithmetic
	logic signed [2*`FB_COORD_W+1:0] sq_x;
	logic signed [2*`FB_COORD_W+1:0] sq_y;
	logic signed [2*`FB_COORD_W+1:0] sq_z;
	dist2_t                          r2_sum;

	always_comb
	begin
		sq_x   = s1_dx * s1_dx; // Always non-negative
		sq_y   = s1_dy * s1_dy;
		sq_z   = s1_dz * s1_dz;
		r2_sum = dist2_t'(sq_x) + dist2_t'(sq_y) + dist2_t'(sq_z);
	end

	////////////////////
	// Valid pipeline
	////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s1_valid  <= 1'b0;
			acc_valid <= 1'b0;
		end
		else
		begin
			s1_valid  <= in_valid;
			acc_valid <= s1_valid && (r2_sum < `FB_CUTOFF_2); // Strictly inside only
		end
	end

	////////////////////
	// Payload pipeline
	////////////////////
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			s1_ref_id <= ref_id;
			s1_nbr_id <= nbr_id;
			s1_dx     <= ref_x - nbr_x; // Sign extended to 17 bits
			s1_dy     <= ref_y - nbr_y;
			s1_dz     <= ref_z - nbr_z;
		end
		if (s1_valid)
		begin
			acc_ref_id <= s1_ref_id;
			acc_nbr_id <= s1_nbr_id;
			acc_dx     <= s1_dx;
			acc_dy     <= s1_dy;
			acc_dz     <= s1_dz;
			acc_r2     <= r2_sum;
		end
	end

endmodule

// File: hw/filter_bank.sv
////////////////////
// Upstream must stop strobing a lane while its back_pressure is high
// No output stall, one pair leaves per cycle while any lane holds data
////////////////////
`timescale 1ns/1ps
`include "filter_bank_defs.svh"

module filter_bank
(
	input  logic                                         clk,
	input  logic                                         arst_n,
	input  filter_bank_pkg::lane_mask_t                  in_valid,
	input  filter_bank_pkg::pid_t   [`FB_NUM_LANES-1:0]  ref_id,
	input  filter_bank_pkg::pid_t   [`FB_NUM_LANES-1:0]  nbr_id,
	input  filter_bank_pkg::coord_t [`FB_NUM_LANES-1:0]  ref_x,
	input  filter_bank_pkg::coord_t [`FB_NUM_LANES-1:0]  ref_y,
	input  filter_bank_pkg::coord_t [`FB_NUM_LANES-1:0]  ref_z,
	input  filter_bank_pkg::coord_t [`FB_NUM_LANES-1:0]  nbr_x,
	input  filter_bank_pkg::coord_t [`FB_NUM_LANES-1:0]  nbr_y,
	input  filter_bank_pkg::coord_t [`FB_NUM_LANES-1:0]  nbr_z,
	output logic                                         out_valid,
	output filter_bank_pkg::pid_t                        out_ref_id,
	output filter_bank_pkg::pid_t                        out_nbr_id,
	output filter_bank_pkg::delta_t                      out_dx,
	output filter_bank_pkg::delta_t                      out_dy,
	output filter_bank_pkg::delta_t                      out_dz,
	output filter_bank_pkg::dist2_t                      out_r2,
	output filter_bank_pkg::lane_mask_t                  back_pressure,
	output logic                                         all_empty
);
	import filter_bank_pkg::*;

	// Distance stage to buffer
	lane_mask_t                    acc_valid;
	pid_t   [`FB_NUM_LANES-1:0]    acc_ref_id;
	pid_t   [`FB_NUM_LANES-1:0]    acc_nbr_id;
	delta_t [`FB_NUM_LANES-1:0]    acc_dx;
	delta_t [`FB_NUM_LANES-1:0]    acc_dy;
	delta_t [`FB_NUM_LANES-1:0]    acc_dz;
	dist2_t [`FB_NUM_LANES-1:0]    acc_r2;

	// Buffer read side
	lane_mask_t                    available;
	lane_mask_t                    grant;     // Also the pop of each lane
	pid_t   [`FB_NUM_LANES-1:0]    rd_ref_id;
	pid_t   [`FB_NUM_LANES-1:0]    rd_nbr_id;
	delta_t [`FB_NUM_LANES-1:0]    rd_dx;
	delta_t [`FB_NUM_LANES-1:0]    rd_dy;
	delta_t [`FB_NUM_LANES-1:0]    rd_dz;
	dist2_t [`FB_NUM_LANES-1:0]    rd_r2;

	// Generator may move to the next reference particle
	assign all_empty = ~|available;

	////////////////////
	// Filter lanes
	////////////////////
	for (genvar i = 0; i < `FB_NUM_LANES; i++)
	begin : g_lane
		pair_distance pair_distance_inst
		(
			.clk        (clk),
			.arst_n     (arst_n),
			.in_valid   (in_valid[i]),
			.ref_id     (ref_id[i]),
			.nbr_id     (nbr_id[i]),
			.ref_x      (ref_x[i]),
			.ref_y      (ref_y[i]),
			.ref_z      (ref_z[i]),
			.nbr_x      (nbr_x[i]),
			.nbr_y      (nbr_y[i]),
			.nbr_z      (nbr_z[i]),
			.acc_valid  (acc_valid[i]),
			.acc_ref_id (acc_ref_id[i]),
			.acc_nbr_id (acc_nbr_id[i]),
			.acc_dx     (acc_dx[i]),
			.acc_dy     (acc_dy[i]),
			.acc_dz     (acc_dz[i]),
			.acc_r2     (acc_r2[i])
		);

		pair_buffer pair_buffer_inst
		(
			.clk           (clk),
			.arst_n        (arst_n),
			.wr_valid      (acc_valid[i]),
			.wr_ref_id     (acc_ref_id[i]),
			.wr_nbr_id     (acc_nbr_id[i]),
			.wr_dx         (acc_dx[i]),
			.wr_dy         (acc_dy[i]),
			.wr_dz         (acc_dz[i]),
			.wr_r2         (acc_r2[i]),
			.pop           (grant[i]),
			.available     (available[i]),
			.back_pressure (back_pressure[i]),
			.rd_ref_id     (rd_ref_id[i]),
			.rd_nbr_id     (rd_nbr_id[i]),
			.rd_dx         (rd_dx[i]),
			.rd_dy         (rd_dy[i]),
			.rd_dz         (rd_dz[i]),
			.rd_r2         (rd_r2[i])
		);
	end

	pair_arbiter pair_arbiter_inst
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.available (available),
		.grant     (grant)
	);

	pair_selector pair_selector_inst
	(
		.clk         (clk),
		.arst_n      (arst_n),
		.grant       (grant),
		.lane_ref_id (rd_ref_id),
		.lane_nbr_id (rd_nbr_id),
		.lane_dx     (rd_dx),
		.lane_dy     (rd_dy),
		.lane_dz     (rd_dz),
		.lane_r2     (rd_r2),
		.out_valid   (out_valid),
		.out_ref_id  (out_ref_id),
		.out_nbr_id  (out_nbr_id),
		.out_dx      (out_dx),
		.out_dy      (out_dy),
		.out_dz      (out_dz),
		.out_r2      (out_r2)
	);

endmodule

// File: hw/pair_arbiter.sv
////////////////////
// Grant is combinational from available, at most one bit set
////////////////////
`timescale 1ns/1ps
`include "filter_bank_defs.svh"

module pair_arbiter
(
	input  logic                        clk,
	input  logic                        arst_n,
	input  filter_bank_pkg::lane_mask_t available,
	output filter_bank_pkg::lane_mask_t grant
);
	localparam int LW = (`FB_NUM_LANES > 1) ? $clog2(`FB_NUM_LANES) : 1;

	logic [LW-1:0] ptr;       // Lane with top priority
	logic [LW-1:0] grant_idx;

	// Search from the pointer, wrapping around
	always_comb
	begin
		int   idx;
		logic found;
		grant     = '0;
		grant_idx = ptr;
		found     = 1'b0;
		for (int k = 0; k < `FB_NUM_LANES; k++)
		begin
			idx = (int'(ptr) + k) % `FB_NUM_LANES;
			if (!found && available[idx])
			begin
				grant[idx] = 1'b1;
				grant_idx  = LW'(idx);
				found      = 1'b1;
			end
		end
	end

	// Step past the lane just served
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			ptr <= '0;
		else if (|grant)
			ptr <= (grant_idx == LW'(`FB_NUM_LANES - 1)) ? '0 : grant_idx + 1'b1;
	end

endmodule

// File: hw/pair_selector.sv
////////////////////
// Ids hold their last value while idle, the numeric fields return to zero
////////////////////
`timescale 1ns/1ps
`include "filter_bank_defs.svh"

module pair_selector
(
	input  logic                                         clk,
	input  logic                                         arst_n,
	input  filter_bank_pkg::lane_mask_t                  grant,
	input  filter_bank_pkg::pid_t   [`FB_NUM_LANES-1:0]  lane_ref_id,
	input  filter_bank_pkg::pid_t   [`FB_NUM_LANES-1:0]  lane_nbr_id,
	input  filter_bank_pkg::delta_t [`FB_NUM_LANES-1:0]  lane_dx,
	input  filter_bank_pkg::delta_t [`FB_NUM_LANES-1:0]  lane_dy,
	input  filter_bank_pkg::delta_t [`FB_NUM_LANES-1:0]  lane_dz,
	input  filter_bank_pkg::dist2_t [`FB_NUM_LANES-1:0]  lane_r2,
	output logic                                         out_valid,
	output filter_bank_pkg::pid_t                        out_ref_id,
	output filter_bank_pkg::pid_t                        out_nbr_id,
	output filter_bank_pkg::delta_t                      out_dx,
	output filter_bank_pkg::delta_t                      out_dy,
	output filter_bank_pkg::delta_t                      out_dz,
	output filter_bank_pkg::dist2_t                      out_r2
);
	import filter_bank_pkg::*;

	localparam int LW = (`FB_NUM_LANES > 1) ? $clog2(`FB_NUM_LANES) : 1;

	lane_mask_t    grant_q;  // Lines up with the buffer read register
	logic [LW-1:0] sel_idx;

	// One-hot to index
	always_comb
	begin
		sel_idx = '0;
		for (int i = 0; i < `FB_NUM_LANES; i++)
			if (grant_q[i])
				sel_idx = LW'(i);
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			grant_q   <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			grant_q   <= grant;
			out_valid <= |grant_q; // Single cycle per pop
		end
	end

	////////////////////
	// Output registers
	////////////////////
	always_ff @(posedge clk)
	begin
		if (|grant_q)
		begin
			out_ref_id <= lane_ref_id[sel_idx];
			out_nbr_id <= lane_nbr_id[sel_idx];
			out_dx     <= lane_dx[sel_idx];
			out_dy     <= lane_dy[sel_idx];
			out_dz     <= lane_dz[sel_idx];
			out_r2     <= lane_r2[sel_idx];
		end
		else
		begin
			out_dx <= '0;
			out_dy <= '0;
			out_dz <= '0;
			out_r2 <= '0;
		end
	end

endmodule

// File: tb.f
+incdir+common
common/filter_bank_pkg.sv
filter_lane/pair_distance.sv
filter_lane/pair_buffer.sv
hw/pair_arbiter.sv
hw/pair_selector.sv
hw/filter_bank.sv
verification/filter_bank_tb.sv

// File: verification/filter_bank_tb.sv
////////////////////
// Lane number rides in the top two bits of ref_id, so at most four lanes
// Model expectations update on the falling edge, assertions sample on the rising edge
////////////////////
`timescale 1ns/1ps
`include "filter_bank_defs.svh"

module filter_bank_tb;
	import filter_bank_pkg::*;

	localparam int NL          = `FB_NUM_LANES;
	localparam int LANE_SHIFT  = `FB_ID_W - 2;
	localparam int MIX_CYC     = 300;
	localparam int FAR_CYC     = 60;
	localparam int SAT_CYC     = 200;
	localparam int EDGE_PAIRS  = 4;
	localparam int MAX_STROBES = NL * (MIX_CYC + FAR_CYC + SAT_CYC) + EDGE_PAIRS;
	localparam int CYCLE_LIMIT = 2 * MAX_STROBES + 200;

	typedef struct packed
	{
		pid_t   ref_id;
		pid_t   nbr_id;
		delta_t dx;
		delta_t dy;
		delta_t dz;
		dist2_t r2;
	} pair_t;

	logic              clk;
	logic              arst_n;
	lane_mask_t        in_valid;
	pid_t   [NL-1:0]   ref_id;
	pid_t   [NL-1:0]   nbr_id;
	coord_t [NL-1:0]   ref_x;
	coord_t [NL-1:0]   ref_y;
	coord_t [NL-1:0]   ref_z;
	coord_t [NL-1:0]   nbr_x;
	coord_t [NL-1:0]   nbr_y;
	coord_t [NL-1:0]   nbr_z;
	logic              out_valid;
	pid_t              out_ref_id;
	pid_t              out_nbr_id;
	delta_t            out_dx;
	delta_t            out_dy;
	delta_t            out_dz;
	dist2_t            out_r2;
	lane_mask_t        back_pressure;
	logic              all_empty;

	// Reference model state
	pair_t      lane_q [NL][$];   // Accepted pairs not yet seen at the output
	pair_t      exp_pair;
	int         seed       = 90686;
	int         seq        = 0;
	int         cycles     = 0;
	int         acc_driven = 0;   // Accepted strobes driven so far
	int         out_count  = 0;
	int         acc_hist [5];
	int         lane;
	int         orphan_lane;
	int         out_lane;
	int         exp_lane;
	int         rr_next;
	bit         rr_ok;
	bit         rr_armed   = 1'b0;
	bit         chk_valid  = 1'b0;
	bit         chk_rr     = 1'b0;
	bit         orphan     = 1'b0;
	bit         exp_empty  = 1'b1;
	bit         act_empty  = 1'b1;
	bit         prev_empty = 1'b1;
	lane_mask_t bp_seen    = '0;

	filter_bank filter_bank_inst
	(
		.clk           (clk),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.ref_id        (ref_id),
		.nbr_id        (nbr_id),
		.ref_x         (ref_x),
		.ref_y         (ref_y),
		.ref_z         (ref_z),
		.nbr_x         (nbr_x),
		.nbr_y         (nbr_y),
		.nbr_z         (nbr_z),
		.out_valid     (out_valid),
		.out_ref_id    (out_ref_id),
		.out_nbr_id    (out_nbr_id),
		.out_dx        (out_dx),
		.out_dy        (out_dy),
		.out_dz        (out_dz),
		.out_r2        (out_r2),
		.back_pressure (back_pressure),
		.all_empty     (all_empty)
	);

	initial
		clk = 1'b0;
	always #10 clk = ~clk;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic report_mismatch(input string name, input longint expv, input longint actv);
		abort_run($sformatf("** Error at %0d ns: %s expected %0d, got %0d",
			$time, name, expv, actv));
	endtask

	function automatic bit queues_empty();
		for (int i = 0; i < NL; i++)
			if (lane_q[i].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	// Neighbor sits at reference minus the offsets
	task automatic put_pair(input int ln, input int ox, input int oy, input int oz);
		int     rx;
		int     ry;
		int     rz;
		longint r2;
		pair_t  p;
		rx = $random(seed) % 8192;
		ry = $random(seed) % 8192;
		rz = $random(seed) % 8192;
		ref_x[ln]    = coord_t'(rx);
		ref_y[ln]    = coord_t'(ry);
		ref_z[ln]    = coord_t'(rz);
		nbr_x[ln]    = coord_t'(rx - ox);
		nbr_y[ln]    = coord_t'(ry - oy);
		nbr_z[ln]    = coord_t'(rz - oz);
		ref_id[ln]   = pid_t'((ln << LANE_SHIFT) | (seq % (1 << LANE_SHIFT)));
		nbr_id[ln]   = pid_t'($random(seed));
		in_valid[ln] = 1'b1;
		seq++;
		p.ref_id = ref_id[ln];
		p.nbr_id = nbr_id[ln];
		p.dx     = delta_t'(int'(ref_x[ln]) - int'(nbr_x[ln]));
		p.dy     = delta_t'(int'(ref_y[ln]) - int'(nbr_y[ln]));
		p.dz     = delta_t'(int'(ref_z[ln]) - int'(nbr_z[ln]));
		r2 = longint'(p.dx) * p.dx + longint'(p.dy) * p.dy + longint'(p.dz) * p.dz;
		p.r2 = dist2_t'(r2);
		if (r2 < longint'(`FB_CUTOFF_2)) // Kept only strictly inside
		begin
			lane_q[ln].push_back(p);
			acc_driven++;
		end
	endtask

	task automatic drive_cycle(input lane_mask_t pick, input bit far, input int spread);
		int ox;
		in_valid = '0;
		bp_seen  = bp_seen | back_pressure;
		for (int i = 0; i < NL; i++)
		begin
			if (pick[i] && !back_pressure[i])
			begin
				// Far pairs sit at or past the cutoff on x alone
				ox = far ? 3072 + int'({$random(seed)} % 2048) : $random(seed) % spread;
				put_pair(i, ox, $random(seed) % spread, $random(seed) % spread);
			end
		end
	endtask

	task automatic drain();
		@(posedge clk);
		#2;
		in_valid = '0;
		while (!(queues_empty() && all_empty))
			@(posedge clk);
	endtask

	initial
	begin
		arst_n   = 1'b0;
		in_valid = '0;
		ref_id   = '0;
		nbr_id   = '0;
		ref_x    = '0;
		ref_y    = '0;
		ref_z    = '0;
		nbr_x    = '0;
		nbr_y    = '0;
		nbr_z    = '0;
		repeat (4) @(posedge clk);
		#2;
		arst_n = 1'b1;
		assert (out_valid == 1'b0) else report_mismatch("out_valid", 0, out_valid);
		assert (all_empty == 1'b1) else report_mismatch("all_empty", 1, all_empty);
		assert (back_pressure == '0) else report_mismatch("back_pressure", 0, back_pressure);

		// Pairs right at and just inside the cutoff
		@(posedge clk);
		#2;
		put_pair(0, 3072, 0, 0);
		put_pair(1, 0, -3071, 0);
		put_pair(2, 1774, 1774, 1774);
		put_pair(3, 1773, -1773, 1773);
		drain();

		repeat (MIX_CYC)
		begin
			@(posedge clk);
			#2;
			drive_cycle(lane_mask_t'($random(seed)), 1'b0, 2600);
		end
		drain();

		repeat (FAR_CYC)
		begin
			@(posedge clk);
			#2;
			drive_cycle('1, 1'b1, 2048);
		end
		drain();

		// Every lane every cycle until held off
		repeat (SAT_CYC)
		begin
			@(posedge clk);
			#2;
			drive_cycle('1, 1'b0, 1024);
		end
		drain();

		repeat (6) @(posedge clk);
		if (bp_seen == '1)
		begin
			$display("TEST OK");
			$finish;
		end
		else
			abort_run("back_pressure never rose on every lane");
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles == CYCLE_LIMIT)
			abort_run("Timeout: the bank did not drain all accepted pairs in time");
	end

	////////////////////
	// Model update
	////////////////////
	always @(negedge clk)
	begin
		chk_valid = 1'b0;
		chk_rr    = 1'b0;
		orphan    = 1'b0;
		for (int i = 4; i > 0; i--)
			acc_hist[i] = acc_hist[i-1];
		acc_hist[0] = acc_driven;
		if (!arst_n)
			rr_armed = 1'b0;
		else if (out_valid)
		begin
			lane = int'(out_ref_id[`FB_ID_W-1 -: 2]);
			if (lane_q[lane].size() == 0)
			begin
				orphan      = 1'b1;
				orphan_lane = lane;
			end
			else
			begin
				chk_rr   = rr_armed;
				exp_lane = rr_next;
				out_lane = lane;
				// Six entries cover the distance stages and this pop
				rr_ok = 1'b1;
				for (int i = 0; i < NL; i++)
					if (lane_q[i].size() < 6)
						rr_ok = 1'b0;
				rr_armed  = rr_ok;
				rr_next   = (lane + 1) % NL;
				exp_pair  = lane_q[lane].pop_front();
				chk_valid = 1'b1;
				out_count++;
			end
		end
		else
			rr_armed = 1'b0;
		// Buffers after edge e hold pairs strobed up to e-2, minus pops seen by now
		exp_empty  = (acc_hist[4] == out_count);
		act_empty  = prev_empty;
		prev_empty = all_empty;
	end

	////////////////////
	// Checks
	////////////////////
	assert property (@(posedge clk) disable iff (!arst_n) !orphan)
		else abort_run($sformatf("out_valid on lane %0d with no pending pair", orphan_lane));
	assert property (@(posedge clk) disable iff (!arst_n) chk_valid |-> out_ref_id == exp_pair.ref_id)
		else report_mismatch("out_ref_id", exp_pair.ref_id, $sampled(out_ref_id));
	assert property (@(posedge clk) disable iff (!arst_n) chk_valid |-> out_nbr_id == exp_pair.nbr_id)
		else report_mismatch("out_nbr_id", exp_pair.nbr_id, $sampled(out_nbr_id));
	assert property (@(posedge clk) disable iff (!arst_n) chk_valid |-> out_dx == exp_pair.dx)
		else report_mismatch("out_dx", exp_pair.dx, $sampled(out_dx));
	assert property (@(posedge clk) disable iff (!arst_n) chk_valid |-> out_dy == exp_pair.dy)
		else report_mismatch("out_dy", exp_pair.dy, $sampled(out_dy));
	assert property (@(posedge clk) disable iff (!arst_n) chk_valid |-> out_dz == exp_pair.dz)
		else report_mismatch("out_dz", exp_pair.dz, $sampled(out_dz));
	assert property (@(posedge clk) disable iff (!arst_n) chk_valid |-> out_r2 == exp_pair.r2)
		else report_mismatch("out_r2", exp_pair.r2, $sampled(out_r2));

	// Idle payload reads as zero
	assert property (@(posedge clk) disable iff (!arst_n) !out_valid |-> out_dx == '0)
		else report_mismatch("out_dx", 0, $sampled(out_dx));
	assert property (@(posedge clk) disable iff (!arst_n) !out_valid |-> out_dy == '0)
		else report_mismatch("out_dy", 0, $sampled(out_dy));
	assert property (@(posedge clk) disable iff (!arst_n) !out_valid |-> out_dz == '0)
		else report_mismatch("out_dz", 0, $sampled(out_dz));
	assert property (@(posedge clk) disable iff (!arst_n) !out_valid |-> out_r2 == '0)
		else report_mismatch("out_r2", 0, $sampled(out_r2));

	assert property (@(posedge clk) disable iff (!arst_n) chk_rr |-> out_lane == exp_lane)
		else report_mismatch("output lane", exp_lane, out_lane);
	assert property (@(posedge clk) disable iff (!arst_n) act_empty == exp_empty)
		else report_mismatch("all_empty", exp_empty, act_empty);

endmodule
